// File: Bender.yml
package:
  name: tge_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/tge_pkg.sv
      - rtl/tge_cfg_regs.sv
      - rtl/tge_soft_reset.sv
      - rtl/tge_event_trig.sv
      - rtl/tge_led_stretch.sv
      - rtl/tge_activity_stat.sv
      - rtl/tge_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tge_core_props.sv
      - sim/tge_core_tb.sv

// File: all.f
+incdir+include
rtl/tge_pkg.sv
rtl/tge_cfg_regs.sv
rtl/tge_soft_reset.sv
rtl/tge_event_trig.sv
rtl/tge_led_stretch.sv
rtl/tge_activity_stat.sv
rtl/tge_core.sv
sim/tge_core_props.sv
sim/tge_core_tb.sv

// File: include/tge_consts.svh
`ifndef TGE_CONSTS_SVH
`define TGE_CONSTS_SVH

// Widths
`define TGE_REG_ADDR_W      4
`define TGE_CNT_W           16
`define TGE_LED_STRETCH_W   26
`define TGE_NUM_LEDS        3
`define TGE_APP_RST_CYCLES  8

// Register map
`define TGE_A_CTRL          0
`define TGE_A_MAC_HI        1
`define TGE_A_MAC_LO        2
`define TGE_A_IP            3
`define TGE_A_PORT          4
`define TGE_A_GATEWAY       5
`define TGE_A_NETMASK       6
`define TGE_A_STATUS        7
`define TGE_A_RX_GOOD       8
`define TGE_A_RX_BAD        9
`define TGE_A_TX            10

// Configuration defaults
`define TGE_DEF_MAC         48'hffff_ffff_ffff
`define TGE_DEF_IP          32'hffff_ffff
`define TGE_DEF_PORT        16'hffff
`define TGE_DEF_NETMASK     32'hffff_ff00
`define TGE_DEF_GATEWAY     8'h00

`endif

// File: rtl/tge_activity_stat.sv
`timescale 1ns/1ps
`include "tge_consts.svh"

module tge_activity_stat (
  input  logic                      clk,
  input  logic                      app_rst,
  input  tge_pkg::tge_events_t      events,
  input  logic [`TGE_NUM_LEDS-1:0]  active,
  output tge_pkg::tge_counts_t      counts,
  output logic                      led_up,
  output logic                      led_rx,
  output logic                      led_tx
);

  // Frame counters stick at all ones
  always_ff @(posedge clk) begin
    if (app_rst) begin
      counts <= '0;
    end else begin
      if (events.rx_good && !(&counts.rx_good)) begin
        counts.rx_good <= counts.rx_good + 1'b1;
      end
      if (events.rx_bad && !(&counts.rx_bad)) begin
        counts.rx_bad <= counts.rx_bad + 1'b1;
      end
      if (events.tx_start && !(&counts.tx)) begin
        counts.tx <= counts.tx + 1'b1;
      end
    end
  end

  // Stretcher 0 tracks link down
  always_ff @(posedge clk) begin
    if (app_rst) begin
      led_up <= 1'b1;
      led_rx <= 1'b0;
      led_tx <= 1'b0;
    end else begin
      led_up <= ~active[0];
      led_rx <= active[1];
      led_tx <= active[2];
    end
  end

endmodule

// File: rtl/tge_cfg_regs.sv
`timescale 1ns/1ps
`include "tge_consts.svh"

module tge_cfg_regs (
  input  logic                      clk,
  input  logic                      mac_resetRR,
  input  logic                      cfg_wr,
  input  logic                      cfg_rd,
  input  tge_pkg::tge_reg_addr_t    cfg_addr,
  input  tge_pkg::tge_reg_t         cfg_wdata,
  input  tge_pkg::tge_xaui_status_t xaui_status,
  input  logic                      soft_reset_ack,
  input  tge_pkg::tge_counts_t      counts,
  output tge_pkg::tge_reg_t         cfg_rdata,
  output logic                      cfg_rd_valid,
  output tge_pkg::tge_local_cfg_t   local_cfg,
  output logic                      soft_reset
);

  localparam int PAD_W = 32 - `TGE_CNT_W;

  logic              phy_up;
  tge_pkg::tge_reg_t rd_mux;

  // All lanes aligned
  assign phy_up = &xaui_status[6:2];

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      local_cfg.enable  <= 1'b0;
      local_cfg.mac     <= `TGE_DEF_MAC;
      local_cfg.ip      <= `TGE_DEF_IP;
      local_cfg.port    <= `TGE_DEF_PORT;
      local_cfg.gateway <= `TGE_DEF_GATEWAY;
      local_cfg.netmask <= `TGE_DEF_NETMASK;
      soft_reset        <= 1'b0;
    end else if (cfg_wr) begin
      case (cfg_addr)
        `TGE_A_CTRL: begin
          local_cfg.enable <= cfg_wdata[0];
          soft_reset       <= cfg_wdata[1];
        end
        `TGE_A_MAC_HI:  local_cfg.mac[47:32] <= cfg_wdata[15:0];
        `TGE_A_MAC_LO:  local_cfg.mac[31:0]  <= cfg_wdata;
        `TGE_A_IP:      local_cfg.ip         <= cfg_wdata;
        `TGE_A_PORT:    local_cfg.port       <= cfg_wdata[15:0];
        `TGE_A_GATEWAY: local_cfg.gateway    <= cfg_wdata[7:0];
        `TGE_A_NETMASK: local_cfg.netmask    <= cfg_wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_mux = '0;
    case (cfg_addr)
      `TGE_A_CTRL:    rd_mux = {30'b0, soft_reset, local_cfg.enable};
      `TGE_A_MAC_HI:  rd_mux = {16'b0, local_cfg.mac[47:32]};
      `TGE_A_MAC_LO:  rd_mux = local_cfg.mac[31:0];
      `TGE_A_IP:      rd_mux = local_cfg.ip;
      `TGE_A_PORT:    rd_mux = {16'b0, local_cfg.port};
      `TGE_A_GATEWAY: rd_mux = {24'b0, local_cfg.gateway};
      `TGE_A_NETMASK: rd_mux = local_cfg.netmask;
      `TGE_A_STATUS:  rd_mux = {22'b0, soft_reset_ack, phy_up, xaui_status};
      `TGE_A_RX_GOOD: rd_mux = {{PAD_W{1'b0}}, counts.rx_good};
      `TGE_A_RX_BAD:  rd_mux = {{PAD_W{1'b0}}, counts.rx_bad};
      `TGE_A_TX:      rd_mux = {{PAD_W{1'b0}}, counts.tx};
      default:        rd_mux = '0;
    endcase
  end

  // Sampled before any same-cycle write lands
  always_ff @(posedge clk) begin
    if (cfg_rd) begin
      cfg_rdata <= rd_mux;
    end
  end

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      cfg_rd_valid <= 1'b0;
    end else begin
      cfg_rd_valid <= cfg_rd;
    end
  end

endmodule

// File: rtl/tge_core.sv
`timescale 1ns/1ps
`include "tge_consts.svh"

module tge_core #(
  parameter int STRETCH_W = `TGE_LED_STRETCH_W
) (
  input  logic                      clk,
  input  logic                      mac_resetRR,
  input  logic                      cfg_wr,
  input  logic                      cfg_rd,
  input  tge_pkg::tge_reg_addr_t    cfg_addr,
  input  tge_pkg::tge_reg_t         cfg_wdata,
  input  tge_pkg::tge_xaui_status_t xaui_status,
  input  logic                      mac_rx_good_frame,
  input  logic                      mac_rx_bad_frame,
  input  logic                      mac_tx_start,
  output tge_pkg::tge_reg_t         cfg_rdata,
  output logic                      cfg_rd_valid,
  output tge_pkg::tge_local_cfg_t   local_cfg,
  output logic                      app_rst,
  output logic                      led_up,
  output logic                      led_rx,
  output logic                      led_tx
);

  logic                     soft_reset;
  logic                     soft_reset_ack;
  tge_pkg::tge_events_t     events;
  tge_pkg::tge_counts_t     counts;
  logic [`TGE_NUM_LEDS-1:0] led_trig;
  logic [`TGE_NUM_LEDS-1:0] led_active;

  tge_cfg_regs u_cfg_regs (
    .clk            (clk),
    .mac_resetRR    (mac_resetRR),
    .cfg_wr         (cfg_wr),
    .cfg_rd         (cfg_rd),
    .cfg_addr       (cfg_addr),
    .cfg_wdata      (cfg_wdata),
    .xaui_status    (xaui_status),
    .soft_reset_ack (soft_reset_ack),
    .counts         (counts),
    .cfg_rdata      (cfg_rdata),
    .cfg_rd_valid   (cfg_rd_valid),
    .local_cfg      (local_cfg),
    .soft_reset     (soft_reset)
  );

  tge_soft_reset u_soft_reset (
    .clk            (clk),
    .mac_resetRR    (mac_resetRR),
    .soft_reset     (soft_reset),
    .app_rst        (app_rst),
    .soft_reset_ack (soft_reset_ack)
  );

  tge_event_trig u_event_trig (
    .clk               (clk),
    .mac_resetRR       (mac_resetRR),
    .xaui_status       (xaui_status),
    .mac_rx_good_frame (mac_rx_good_frame),
    .mac_rx_bad_frame  (mac_rx_bad_frame),
    .mac_tx_start      (mac_tx_start),
    .events            (events)
  );

  // Stretcher order is link down, rx, tx
  assign led_trig = {events.tx_start, events.rx_good, events.phy_down};

  for (genvar i = 0; i < `TGE_NUM_LEDS; i++) begin : g_led
    tge_led_stretch #(
      .STRETCH_W (STRETCH_W)
    ) u_led_stretch (
      .clk         (clk),
      .mac_resetRR (mac_resetRR),
      .trig        (led_trig[i]),
      .active      (led_active[i])
    );
  end

  tge_activity_stat u_activity_stat (
    .clk     (clk),
    .app_rst (app_rst),
    .events  (events),
    .active  (led_active),
    .counts  (counts),
    .led_up  (led_up),
    .led_rx  (led_rx),
    .led_tx  (led_tx)
  );

endmodule

// File: rtl/tge_event_trig.sv
`timescale 1ns/1ps

module tge_event_trig (
  input  logic                      clk,
  input  logic                      mac_resetRR,
  input  tge_pkg::tge_xaui_status_t xaui_status,
  input  logic                      mac_rx_good_frame,
  input  logic                      mac_rx_bad_frame,
  input  logic                      mac_tx_start,
  output tge_pkg::tge_events_t      events
);

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      events <= '0;
    end else begin
      // Link down whenever a lane drops out of alignment
      events.phy_down <= ~&xaui_status[6:2];
      events.rx_good  <= mac_rx_good_frame;
      events.rx_bad   <= mac_rx_bad_frame;
      events.tx_start <= mac_tx_start;
    end
  end

endmodule

// File: rtl/tge_led_stretch.sv
`timescale 1ns/1ps
`include "tge_consts.svh"

module tge_led_stretch #(
  parameter int STRETCH_W = `TGE_LED_STRETCH_W
) (
  input  logic clk,
  input  logic mac_resetRR,
  input  logic trig,
  output logic active
);

  logic [STRETCH_W-1:0] stretch;

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      stretch <= '0;
    end else if (trig) begin
      stretch <= '1;
    end else if (stretch[STRETCH_W-1]) begin
      // Runs down until the top bit falls, then parks
      stretch <= stretch - 1'b1;
    end
  end

  assign active = stretch[STRETCH_W-1];

endmodule

// File: rtl/tge_pkg.sv
`include "tge_consts.svh"

package tge_pkg;

  typedef logic [47:0]                  tge_mac_t;
  typedef logic [31:0]                  tge_ip_t;
  typedef logic [15:0]                  tge_port_t;
  typedef logic [7:0]                   tge_gateway_t;
  typedef logic [31:0]                  tge_reg_t;
  typedef logic [`TGE_REG_ADDR_W-1:0]   tge_reg_addr_t;
  typedef logic [`TGE_CNT_W-1:0]        tge_cnt_t;
  typedef logic [7:0]                   tge_xaui_status_t;

  typedef struct packed {
    logic         enable;
    tge_mac_t     mac;
    tge_ip_t      ip;
    tge_port_t    port;
    tge_gateway_t gateway;
    tge_ip_t      netmask;
  } tge_local_cfg_t;

  // One cycle late copies of the MAC strobes and link state
  typedef struct packed {
    logic phy_down;
    logic rx_good;
    logic rx_bad;
    logic tx_start;
  } tge_events_t;

  typedef struct packed {
    tge_cnt_t rx_good;
    tge_cnt_t rx_bad;
    tge_cnt_t tx;
  } tge_counts_t;

  typedef enum logic [1:0] {SWR_IDLE, SWR_RESET, SWR_ACK} tge_swr_state_t;

endpackage

// File: rtl/tge_soft_reset.sv
`timescale 1ns/1ps
`include "tge_consts.svh"

module tge_soft_reset (
  input  logic clk,
  input  logic mac_resetRR,
  input  logic soft_reset,
  output logic app_rst,
  output logic soft_reset_ack
);

  localparam int CNT_W = $clog2(`TGE_APP_RST_CYCLES + 1);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`TGE_APP_RST_CYCLES - 1);

  tge_pkg::tge_swr_state_t state;
  tge_pkg::tge_swr_state_t state_nxt;
  logic [CNT_W-1:0]        cnt;

  always_comb begin
    state_nxt = state;
    case (state)
      tge_pkg::SWR_IDLE:  if (soft_reset) state_nxt = tge_pkg::SWR_RESET;
      tge_pkg::SWR_RESET: if (cnt == LAST) state_nxt = tge_pkg::SWR_ACK;
      tge_pkg::SWR_ACK:   if (!soft_reset) state_nxt = tge_pkg::SWR_IDLE;
      default:            state_nxt = tge_pkg::SWR_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (mac_resetRR) begin
      state <= tge_pkg::SWR_IDLE;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      // Counts reset cycles, restarts on every entry
      if (state == tge_pkg::SWR_RESET) begin
        cnt <= cnt + 1'b1;
      end else begin
        cnt <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    app_rst <= mac_resetRR || (state == tge_pkg::SWR_RESET);
  end

  assign soft_reset_ack = (state == tge_pkg::SWR_ACK);

endmodule

// File: sim/tge_core_props.sv
`timescale 1ns/1ps
`include "tge_consts.svh"

module tge_core_props (
  input logic clk,
  input logic mac_resetRR,
  input logic cfg_rd,
  input logic cfg_rd_valid,
  input logic app_rst,
  input logic mac_rx_good_frame,
  input logic led_rx,
  input logic led_tx,
  input logic soft_reset,
  input logic soft_reset_ack
);

  a_rd_valid_set: assert property (@(posedge clk) disable iff (mac_resetRR)
    cfg_rd |=> cfg_rd_valid)
    else $error("cfg_rd_valid missing one cycle after cfg_rd");

  a_rd_valid_clr: assert property (@(posedge clk) disable iff (mac_resetRR)
    !cfg_rd |=> !cfg_rd_valid)
    else $error("cfg_rd_valid without a preceding cfg_rd");

  // Request seen one cycle later, app_rst registered one more
  a_app_rst_len: assert property (@(posedge clk) disable iff (mac_resetRR)
    $rose(soft_reset) |-> ##2 app_rst [*`TGE_APP_RST_CYCLES] ##1 !app_rst)
    else $error("app_rst pulse from soft reset has the wrong length");

  a_led_rx: assert property (@(posedge clk) disable iff (mac_resetRR || app_rst)
    mac_rx_good_frame |-> ##3 led_rx)
    else $error("led_rx not high three cycles after rx good frame");

  a_reset_state: assert property (@(posedge clk)
    $fell(mac_resetRR) |-> !cfg_rd_valid && !soft_reset && !soft_reset_ack
                           && !led_rx && !led_tx && app_rst)
    else $error("control outputs not in reset state after mac_resetRR");

endmodule

bind tge_core tge_core_props u_props (
  .clk               (clk),
  .mac_resetRR       (mac_resetRR),
  .cfg_rd            (cfg_rd),
  .cfg_rd_valid      (cfg_rd_valid),
  .app_rst           (app_rst),
  .mac_rx_good_frame (mac_rx_good_frame),
  .led_rx            (led_rx),
  .led_tx            (led_tx),
  .soft_reset        (soft_reset),
  .soft_reset_ack    (soft_reset_ack)
);

// File: sim/tge_core_tb.sv
`timescale 1ns/1ps
`include "tge_consts.svh"

module tge_core_tb;

  localparam int STRETCH_W       = 6;
  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 16;
  localparam int MAX_STEP_CYCLES = 64;
  localparam int LED_DELAY       = 3;
  localparam int LED_HOLD        = 1 << (STRETCH_W - 1);

  typedef enum logic [3:0] {
    OP_WRITE, OP_READ, OP_BURST, OP_IDLE, OP_LED_RX, OP_LED_TX,
    OP_LINK, OP_SOFT_RST, OP_LEDS, OP_CFG
  } op_t;

  typedef struct packed {
    op_t                    op;
    tge_pkg::tge_reg_addr_t addr;
    logic                   rnd;
    tge_pkg::tge_reg_t      data;
  } step_t;

  logic                      clk = 1'b0;
  logic                      mac_resetRR;
  logic                      cfg_wr;
  logic                      cfg_rd;
  tge_pkg::tge_reg_addr_t    cfg_addr;
  tge_pkg::tge_reg_t         cfg_wdata;
  tge_pkg::tge_xaui_status_t xaui_status;
  logic                      mac_rx_good_frame;
  logic                      mac_rx_bad_frame;
  logic                      mac_tx_start;
  tge_pkg::tge_reg_t         cfg_rdata;
  logic                      cfg_rd_valid;
  tge_pkg::tge_local_cfg_t   local_cfg;
  logic                      app_rst;
  logic                      led_up;
  logic                      led_rx;
  logic                      led_tx;

  step_t                   steps[$];
  logic [31:0]             lfsr_state;
  longint                  limit_ns = 0;
  int                      checks = 0;
  int                      value_errors = 0;
  int                      other_errors = 0;
  // Reference state of the register map
  tge_pkg::tge_local_cfg_t model_cfg;
  tge_pkg::tge_counts_t    model_counts;
  tge_pkg::tge_xaui_status_t model_xaui;
  logic                    model_soft;
  logic                    model_ack;

  tge_core #(.STRETCH_W(STRETCH_W)) u_dut (
    .clk               (clk),
    .mac_resetRR       (mac_resetRR),
    .cfg_wr            (cfg_wr),
    .cfg_rd            (cfg_rd),
    .cfg_addr          (cfg_addr),
    .cfg_wdata         (cfg_wdata),
    .xaui_status       (xaui_status),
    .mac_rx_good_frame (mac_rx_good_frame),
    .mac_rx_bad_frame  (mac_rx_bad_frame),
    .mac_tx_start      (mac_tx_start),
    .cfg_rdata         (cfg_rdata),
    .cfg_rd_valid      (cfg_rd_valid),
    .local_cfg         (local_cfg),
    .app_rst           (app_rst),
    .led_up            (led_up),
    .led_rx            (led_rx),
    .led_tx            (led_tx)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_next_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic tge_pkg::tge_reg_t rand_bits(input int n);
    tge_pkg::tge_reg_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_next_bit()};
    end
    return v;
  endfunction

  function automatic tge_pkg::tge_cnt_t sat_inc(input tge_pkg::tge_cnt_t c);
    return (&c) ? c : c + 1'b1;
  endfunction

  function automatic void model_write(input tge_pkg::tge_reg_addr_t a,
                                      input tge_pkg::tge_reg_t d);
    case (a)
      `TGE_A_CTRL: begin
        model_cfg.enable = d[0];
        model_soft = d[1];
        if (!d[1]) begin
          model_ack = 1'b0;
        end
      end
      `TGE_A_MAC_HI:  model_cfg.mac[47:32] = d[15:0];
      `TGE_A_MAC_LO:  model_cfg.mac[31:0]  = d;
      `TGE_A_IP:      model_cfg.ip         = d;
      `TGE_A_PORT:    model_cfg.port       = d[15:0];
      `TGE_A_GATEWAY: model_cfg.gateway    = d[7:0];
      `TGE_A_NETMASK: model_cfg.netmask    = d;
      default: ;
    endcase
  endfunction

  function automatic tge_pkg::tge_reg_t model_read(input tge_pkg::tge_reg_addr_t a);
    case (a)
      `TGE_A_CTRL:    return {30'b0, model_soft, model_cfg.enable};
      `TGE_A_MAC_HI:  return {16'b0, model_cfg.mac[47:32]};
      `TGE_A_MAC_LO:  return model_cfg.mac[31:0];
      `TGE_A_IP:      return model_cfg.ip;
      `TGE_A_PORT:    return {16'b0, model_cfg.port};
      `TGE_A_GATEWAY: return {24'b0, model_cfg.gateway};
      `TGE_A_NETMASK: return model_cfg.netmask;
      `TGE_A_STATUS:  return {22'b0, model_ack, &model_xaui[6:2], model_xaui};
      `TGE_A_RX_GOOD: return 32'(model_counts.rx_good);
      `TGE_A_RX_BAD:  return 32'(model_counts.rx_bad);
      `TGE_A_TX:      return 32'(model_counts.tx);
      default:        return '0;
    endcase
  endfunction

  task automatic check_reg(input string name, input tge_pkg::tge_reg_t exp,
                           input tge_pkg::tge_reg_t act);
    checks++;
    if (act !== exp) begin
      value_errors++;
      $display("Fail at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_cnt(input string name, input tge_pkg::tge_cnt_t exp,
                           input tge_pkg::tge_cnt_t act);
    checks++;
    if (act !== exp) begin
      value_errors++;
      $display("Fail at %0t: %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_cfg(input string name, input tge_pkg::tge_local_cfg_t exp,
                           input tge_pkg::tge_local_cfg_t act);
    checks++;
    if (act !== exp) begin
      value_errors++;
      $display("Fail at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      value_errors++;
      $display("Fail at %0t: %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic check_len(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      value_errors++;
      $display("Fail at %0t: %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic write_reg(input tge_pkg::tge_reg_addr_t a, input tge_pkg::tge_reg_t d);
    @(posedge clk);
    cfg_wr    <= 1'b1;
    cfg_addr  <= a;
    cfg_wdata <= d;
    @(posedge clk);
    cfg_wr <= 1'b0;
    model_write(a, d);
    @(negedge clk);
    check_cfg("local_cfg", model_cfg, local_cfg);
  endtask

  task automatic read_reg(input tge_pkg::tge_reg_addr_t a, output tge_pkg::tge_reg_t d);
    int waited;
    @(posedge clk);
    cfg_rd   <= 1'b1;
    cfg_addr <= a;
    @(posedge clk);
    cfg_rd <= 1'b0;
    @(negedge clk);
    waited = 0;
    while (!cfg_rd_valid && waited < 8) begin
      @(negedge clk);
      waited++;
    end
    if (!cfg_rd_valid) begin
      other_errors++;
      $display("Read of address %0d got no cfg_rd_valid at %0t", a, $time);
    end
    d = cfg_rdata;
  endtask

  task automatic run_burst(input int cycles);
    tge_pkg::tge_reg_t ev;
    for (int c = 0; c < cycles; c++) begin
      ev = rand_bits(3);
      @(posedge clk);
      mac_rx_good_frame <= ev[0];
      mac_rx_bad_frame  <= ev[1];
      mac_tx_start      <= ev[2];
      if (ev[0]) model_counts.rx_good = sat_inc(model_counts.rx_good);
      if (ev[1]) model_counts.rx_bad = sat_inc(model_counts.rx_bad);
      if (ev[2]) model_counts.tx = sat_inc(model_counts.tx);
    end
    @(posedge clk);
    mac_rx_good_frame <= 1'b0;
    mac_rx_bad_frame  <= 1'b0;
    mac_tx_start      <= 1'b0;
  endtask

  // Single strobe, then the LED traced cycle by cycle
  task automatic led_timing(input logic tx);
    logic exp;
    @(posedge clk);
    if (tx) begin
      mac_tx_start <= 1'b1;
      model_counts.tx = sat_inc(model_counts.tx);
    end else begin
      mac_rx_good_frame <= 1'b1;
      model_counts.rx_good = sat_inc(model_counts.rx_good);
    end
    for (int i = 1; i <= LED_DELAY + LED_HOLD + 1; i++) begin
      @(posedge clk);
      mac_rx_good_frame <= 1'b0;
      mac_tx_start      <= 1'b0;
      @(negedge clk);
      exp = (i >= LED_DELAY) && (i < LED_DELAY + LED_HOLD);
      if (tx) begin
        check_bit("led_tx", exp, led_tx);
      end else begin
        check_bit("led_rx", exp, led_rx);
      end
    end
  endtask

  task automatic set_lanes(input step_t s);
    tge_pkg::tge_reg_t r;
    tge_pkg::tge_xaui_status_t v;
    r = rand_bits(6);
    // Random lane among bits 6 to 2 pulled low
    v = s.rnd ? ({r[5], 5'b11111, r[4:3]} & ~(8'h04 << (r[2:0] % 5))) : s.data[7:0];
    @(posedge clk);
    xaui_status <= v;
    model_xaui = v;
  endtask

  task automatic run_soft_reset();
    int waited;
    int len;
    write_reg(`TGE_A_CTRL, {30'b0, 1'b1, model_cfg.enable});
    waited = 0;
    while (!app_rst && waited < 16) begin
      @(negedge clk);
      waited++;
    end
    if (!app_rst) begin
      other_errors++;
      $display("app_rst never rose after the soft reset write at %0t", $time);
    end else begin
      len = 0;
      while (app_rst && len < 32) begin
        len++;
        @(negedge clk);
      end
      check_len("app_rst cycles", `TGE_APP_RST_CYCLES, len);
      model_counts = '0;
      model_ack = 1'b1;
    end
  endtask

  task automatic run_step(input step_t s);
    tge_pkg::tge_reg_t rdata;
    tge_pkg::tge_reg_t exp;
    case (s.op)
      OP_WRITE: write_reg(s.addr, s.rnd ? rand_bits(32) : s.data);
      OP_READ: begin
        read_reg(s.addr, rdata);
        exp = model_read(s.addr);
        if (s.addr >= `TGE_A_RX_GOOD && s.addr <= `TGE_A_TX) begin
          check_cnt($sformatf("count at %0d", s.addr), exp[15:0], rdata[15:0]);
          check_reg($sformatf("cfg_rdata upper at %0d", s.addr), '0, rdata >> 16);
        end else begin
          check_reg($sformatf("cfg_rdata at %0d", s.addr), exp, rdata);
        end
      end
      OP_BURST:    run_burst(int'(s.data));
      OP_IDLE:     repeat (int'(s.data)) @(posedge clk);
      OP_LED_RX:   led_timing(1'b0);
      OP_LED_TX:   led_timing(1'b1);
      OP_LINK:     set_lanes(s);
      OP_SOFT_RST: run_soft_reset();
      OP_LEDS: begin
        @(negedge clk);
        check_bit("led_up", s.data[0], led_up);
        check_bit("led_rx", s.data[1], led_rx);
        check_bit("led_tx", s.data[2], led_tx);
      end
      OP_CFG: begin
        @(negedge clk);
        check_cfg("local_cfg", model_cfg, local_cfg);
      end
      default: ;
    endcase
  endtask

  function automatic step_t make_step(input op_t op, input int a, input logic rnd,
                                      input tge_pkg::tge_reg_t d);
    step_t s;
    s.op   = op;
    s.addr = tge_pkg::tge_reg_addr_t'(a);
    s.rnd  = rnd;
    s.data = d;
    return s;
  endfunction

  task automatic build_table();
    steps.push_back(make_step(OP_CFG, 0, 0, 0));
    steps.push_back(make_step(OP_LEDS, 0, 0, 1));
    for (int a = 0; a < 16; a++) begin
      steps.push_back(make_step(OP_READ, a, 0, 0));
    end
    steps.push_back(make_step(OP_WRITE, `TGE_A_CTRL, 0, 1));
    for (int a = `TGE_A_MAC_HI; a <= `TGE_A_NETMASK; a++) begin
      steps.push_back(make_step(OP_WRITE, a, 1, 0));
      steps.push_back(make_step(OP_READ, a, 0, 0));
    end
    steps.push_back(make_step(OP_WRITE, 12, 1, 0));
    steps.push_back(make_step(OP_READ, 12, 0, 0));
    steps.push_back(make_step(OP_WRITE, `TGE_A_STATUS, 1, 0));
    steps.push_back(make_step(OP_READ, `TGE_A_STATUS, 0, 0));
    steps.push_back(make_step(OP_READ, `TGE_A_CTRL, 0, 0));
    for (int i = 0; i < 3; i++) begin
      steps.push_back(make_step(OP_BURST, 0, 0, 20));
      steps.push_back(make_step(OP_IDLE, 0, 0, 3));
      for (int a = `TGE_A_RX_GOOD; a <= `TGE_A_TX; a++) begin
        steps.push_back(make_step(OP_READ, a, 0, 0));
      end
    end
    steps.push_back(make_step(OP_IDLE, 0, 0, 40));
    steps.push_back(make_step(OP_LEDS, 0, 0, 1));
    steps.push_back(make_step(OP_LED_RX, 0, 0, 0));
    steps.push_back(make_step(OP_READ, `TGE_A_RX_GOOD, 0, 0));
    steps.push_back(make_step(OP_LED_TX, 0, 0, 0));
    steps.push_back(make_step(OP_READ, `TGE_A_TX, 0, 0));
    steps.push_back(make_step(OP_LINK, 0, 1, 0));
    steps.push_back(make_step(OP_IDLE, 0, 0, 4));
    steps.push_back(make_step(OP_LEDS, 0, 0, 0));
    steps.push_back(make_step(OP_READ, `TGE_A_STATUS, 0, 0));
    steps.push_back(make_step(OP_LINK, 0, 0, 32'hfd));
    steps.push_back(make_step(OP_READ, `TGE_A_STATUS, 0, 0));
    steps.push_back(make_step(OP_IDLE, 0, 0, 40));
    steps.push_back(make_step(OP_LEDS, 0, 0, 1));
    steps.push_back(make_step(OP_BURST, 0, 0, 16));
    steps.push_back(make_step(OP_IDLE, 0, 0, 3));
    steps.push_back(make_step(OP_SOFT_RST, 0, 0, 0));
    for (int a = `TGE_A_CTRL; a <= `TGE_A_TX; a++) begin
      steps.push_back(make_step(OP_READ, a, 0, 0));
    end
    steps.push_back(make_step(OP_CFG, 0, 0, 0));
    steps.push_back(make_step(OP_WRITE, `TGE_A_CTRL, 0, 1));
    steps.push_back(make_step(OP_IDLE, 0, 0, 2));
    steps.push_back(make_step(OP_READ, `TGE_A_STATUS, 0, 0));
    steps.push_back(make_step(OP_READ, `TGE_A_CTRL, 0, 0));
    steps.push_back(make_step(OP_BURST, 0, 0, 10));
    steps.push_back(make_step(OP_IDLE, 0, 0, 3));
    for (int a = `TGE_A_RX_GOOD; a <= `TGE_A_TX; a++) begin
      steps.push_back(make_step(OP_READ, a, 0, 0));
    end
  endtask

  initial begin
    mac_resetRR       = 1'b1;
    cfg_wr            = 1'b0;
    cfg_rd            = 1'b0;
    cfg_addr          = '0;
    cfg_wdata         = '0;
    xaui_status       = 8'h7c;
    mac_rx_good_frame = 1'b0;
    mac_rx_bad_frame  = 1'b0;
    mac_tx_start      = 1'b0;
    lfsr_state        = 32'h1ec9;
    model_cfg.enable  = 1'b0;
    model_cfg.mac     = `TGE_DEF_MAC;
    model_cfg.ip      = `TGE_DEF_IP;
    model_cfg.port    = `TGE_DEF_PORT;
    model_cfg.gateway = `TGE_DEF_GATEWAY;
    model_cfg.netmask = `TGE_DEF_NETMASK;
    model_counts      = '0;
    model_xaui        = 8'h7c;
    model_soft        = 1'b0;
    model_ack         = 1'b0;
    build_table();
    limit_ns = longint'(RESET_CYCLES + steps.size() * MAX_STEP_CYCLES + 100) * CLK_PERIOD;
    repeat (RESET_CYCLES) @(posedge clk);
    mac_resetRR <= 1'b0;
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    repeat (2) @(posedge clk);
    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    wait (limit_ns != 0);
    #(limit_ns);
    $display("Watchdog expired after %0d ns, the test table did not complete", limit_ns);
    $display(">>> FAIL");
    $finish;
  end

endmodule
